//--- verilog/system_types_pkg.sv
package system_types_pkg;

    // ----------------------------------------
    // virtual address space

    // 4 KiB pages
    localparam int VPN_WIDTH = 20;
    localparam int PO_WIDTH  = 12;

    // full virtual address
    typedef logic [31:0] va32_t;

    // virtual page number
    typedef logic [VPN_WIDTH-1:0] vpn_t;

    // word index within a page, byte bits dropped
    typedef logic [PO_WIDTH-3:0] po_word_t;

endpackage

//--- verilog/core_types_pkg.sv
package core_types_pkg;

    import system_types_pkg::*;

    // ----------------------------------------
    // register file geometry

    localparam int PRF_COUNT          = 32;
    localparam int PRF_BANK_COUNT     = 4;
    localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

    // ----------------------------------------
    // load unit queues

    localparam int LDU_CQ_ENTRIES     = 8;
    localparam int LOG_LDU_CQ_ENTRIES = $clog2(LDU_CQ_ENTRIES);
    localparam int LDU_IQ_ENTRIES     = 4;

    typedef logic [$clog2(PRF_COUNT)-1:0]  preg_t;
    typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;
    typedef logic [LOG_LDU_CQ_ENTRIES-1:0] cq_index_t;
    typedef logic [3:0]                    byte_mask_t;
    typedef logic [31:0]                   word_t;

    // bit 1 marks word, bit 0 marks halfword, bit 2 unsigned
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101
    } ldu_op_t;

    // ----------------------------------------
    // structs between blocks

    typedef struct packed {
        ldu_op_t   op;
        logic [11:0] imm12;
        preg_t     src_preg;
        logic      src_ready;
        cq_index_t cq_index;
    } ldu_dispatch_t;

    typedef struct packed {
        ldu_op_t   op;
        logic [11:0] imm12;
        logic      A_forward;
        logic      A_is_zero;
        bank_t     A_bank;
        cq_index_t cq_index;
    } ldu_issue_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
    } prf_read_req_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
        word_t data;
    } prf_wb_t;

    typedef struct packed {
        logic       is_mq;
        logic       misaligned;
        vpn_t       VPN;
        po_word_t   PO_word;
        byte_mask_t byte_mask;
        cq_index_t  cq_index;
    } ldu_req_t;

endpackage

//--- verilog/ldu_issue_queue.sv
`timescale 1ns/1ps

module ldu_issue_queue
    import core_types_pkg::*;
(
    input  logic          CLK,
    input  logic          nRST,

    // dispatch
    input  logic          dispatch_valid,
    input  ldu_dispatch_t dispatch,
    output logic          dispatch_ready,

    // writeback wakeup
    input  prf_wb_t       wb,

    // issue to address pipeline
    output logic          issue_valid,
    output ldu_issue_t    issue,
    input  logic          issue_ready,

    // operand read for the issued load
    output prf_read_req_t A_reg_read_req,
    input  logic          A_reg_read_ack
);

    typedef logic [$clog2(LDU_IQ_ENTRIES)-1:0] iq_index_t;

    // entry 0 is always the oldest
    ldu_dispatch_t [LDU_IQ_ENTRIES-1:0] entry_q, entry_d;
    logic [LDU_IQ_ENTRIES-1:0] valid_q, valid_d;
    logic [LDU_IQ_ENTRIES-1:0] rdy_q, rdy_d;
    logic [LDU_IQ_ENTRIES-1:0] woken;
    logic [LDU_IQ_ENTRIES-1:0] cand;

    iq_index_t issue_idx;
    iq_index_t free_idx;
    logic      issue_fire;
    logic      dispatch_fire;
    logic      dispatch_woken;

    logic      rd_valid_q;
    preg_t     rd_preg_q;

    // ----------------------------------------
    // wakeup and select

    always_comb begin
        for (int i = 0; i < LDU_IQ_ENTRIES; i++) begin
            woken[i] = valid_q[i] & wb.valid & (wb.preg == entry_q[i].src_preg);
            cand[i]  = valid_q[i] & (rdy_q[i] | woken[i]);
        end
        // last hit wins, so the lowest index is picked
        issue_idx = '0;
        for (int i = LDU_IQ_ENTRIES - 1; i >= 0; i--) begin
            if (cand[i]) begin
                issue_idx = iq_index_t'(i);
            end
        end
    end

    assign issue_valid    = |cand;
    assign issue_fire     = issue_valid & issue_ready;
    assign dispatch_ready = ~valid_q[LDU_IQ_ENTRIES-1];
    assign dispatch_fire  = dispatch_valid & dispatch_ready;
    assign dispatch_woken = wb.valid & (wb.preg == dispatch.src_preg);

    assign issue.op        = entry_q[issue_idx].op;
    assign issue.imm12     = entry_q[issue_idx].imm12;
    // woken this cycle, so the value is only on the forward bus next cycle
    assign issue.A_forward = woken[issue_idx] & ~rdy_q[issue_idx];
    assign issue.A_is_zero = entry_q[issue_idx].src_preg == '0;
    assign issue.A_bank    = bank_t'(entry_q[issue_idx].src_preg);
    assign issue.cq_index  = entry_q[issue_idx].cq_index;

    // ----------------------------------------
    // compaction and allocation

    always_comb begin
        valid_d = valid_q;
        entry_d = entry_q;
        rdy_d   = rdy_q | woken;
        if (issue_fire) begin
            for (int i = 0; i < LDU_IQ_ENTRIES - 1; i++) begin
                if (i >= issue_idx) begin
                    valid_d[i] = valid_q[i+1];
                    entry_d[i] = entry_q[i+1];
                    rdy_d[i]   = rdy_q[i+1] | woken[i+1];
                end
            end
            valid_d[LDU_IQ_ENTRIES-1] = 1'b0;
        end
        free_idx = '0;
        for (int i = LDU_IQ_ENTRIES - 1; i >= 0; i--) begin
            if (~valid_d[i]) begin
                free_idx = iq_index_t'(i);
            end
        end
        if (dispatch_fire) begin
            valid_d[free_idx] = 1'b1;
            entry_d[free_idx] = dispatch;
            rdy_d[free_idx]   = dispatch.src_ready | (dispatch.src_preg == '0) | dispatch_woken;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            valid_q <= '0;
            rdy_q   <= '0;
        end else begin
            valid_q <= valid_d;
            rdy_q   <= rdy_d;
        end
    end

    always_ff @(posedge CLK) begin
        entry_q <= entry_d;
    end

    // ----------------------------------------
    // register read request

    // held until acked or replaced by the next issue
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            rd_valid_q <= 1'b0;
        end else if (issue_fire) begin
            rd_valid_q <= ~issue.A_forward & ~issue.A_is_zero;
        end else if (A_reg_read_ack) begin
            rd_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_fire) begin
            rd_preg_q <= entry_q[issue_idx].src_preg;
        end
    end

    assign A_reg_read_req.valid = rd_valid_q;
    assign A_reg_read_req.preg  = rd_preg_q;

endmodule

//--- verilog/prf_banked.sv
`timescale 1ns/1ps

module prf_banked
    import core_types_pkg::*;
(
    input  logic          CLK,
    input  logic          nRST,

    input  prf_wb_t       wb,

    // external clients in priority order
    input  prf_read_req_t [1:0] ext_read_req,
    output word_t         [1:0] ext_read_data,

    // load unit operand read
    input  prf_read_req_t A_reg_read_req,
    output logic          A_reg_read_ack,
    output logic          A_reg_read_port,

    output word_t [PRF_BANK_COUNT-1:0][1:0] reg_read_data_by_bank_by_port,
    output word_t [PRF_BANK_COUNT-1:0]      forward_data_by_bank
);

    word_t reg_file [PRF_COUNT];

    logic  [PRF_BANK_COUNT-1:0][1:0] port_used;
    preg_t [PRF_BANK_COUNT-1:0][1:0] port_preg;
    logic  [1:0]                     ext_port;
    bank_t ext_bank;
    bank_t a_bank;

    // x0 is hardwired
    function automatic word_t read_reg(preg_t p);
        return (p == '0) ? '0 : reg_file[p];
    endfunction

    // ----------------------------------------
    // write port and forward bus

    always_ff @(posedge CLK) begin
        if (wb.valid && wb.preg != '0) begin
            reg_file[wb.preg] <= wb.data;
        end
    end

    // one cycle of forward data per bank
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            forward_data_by_bank <= '0;
        end else if (wb.valid) begin
            forward_data_by_bank[bank_t'(wb.preg)] <= wb.data;
        end
    end

    // ----------------------------------------
    // read port arbitration

    always_comb begin
        port_used = '0;
        port_preg = '0;
        ext_port  = '0;
        ext_bank  = '0;
        for (int i = 0; i < 2; i++) begin
            if (ext_read_req[i].valid) begin
                ext_bank = bank_t'(ext_read_req[i].preg);
                if (~port_used[ext_bank][0]) begin
                    port_used[ext_bank][0] = 1'b1;
                    port_preg[ext_bank][0] = ext_read_req[i].preg;
                end else begin
                    port_used[ext_bank][1] = 1'b1;
                    port_preg[ext_bank][1] = ext_read_req[i].preg;
                    ext_port[i]            = 1'b1;
                end
            end
        end

        // load unit takes whatever port is left
        a_bank          = bank_t'(A_reg_read_req.preg);
        A_reg_read_ack  = 1'b0;
        A_reg_read_port = 1'b0;
        if (A_reg_read_req.valid) begin
            if (~port_used[a_bank][0]) begin
                A_reg_read_ack         = 1'b1;
                port_preg[a_bank][0]   = A_reg_read_req.preg;
            end else if (~port_used[a_bank][1]) begin
                A_reg_read_ack         = 1'b1;
                A_reg_read_port        = 1'b1;
                port_preg[a_bank][1]   = A_reg_read_req.preg;
            end
        end
    end

    always_comb begin
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            for (int p = 0; p < 2; p++) begin
                reg_read_data_by_bank_by_port[b][p] = read_reg(port_preg[b][p]);
            end
        end
        // external data comes out of the port each client was given
        for (int i = 0; i < 2; i++) begin
            ext_read_data[i] =
                reg_read_data_by_bank_by_port[bank_t'(ext_read_req[i].preg)][ext_port[i]];
        end
    end

endmodule

//--- verilog/ldu_addr_pipeline.sv
`timescale 1ns/1ps

module ldu_addr_pipeline
    import system_types_pkg::*;
    import core_types_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,

    // issue from the queue
    input  logic       issue_valid,
    input  ldu_issue_t issue,
    output logic       issue_ready,

    // register file read result and forward bus
    input  logic       A_reg_read_ack,
    input  logic       A_reg_read_port,
    input  word_t [PRF_BANK_COUNT-1:0][1:0] reg_read_data_by_bank_by_port,
    input  word_t [PRF_BANK_COUNT-1:0]      forward_data_by_bank,

    // request toward TLB and cache
    output logic       REQ_valid,
    output ldu_req_t   REQ,
    input  logic       REQ_ack
);

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_ACTIVE,
        REQ_MISALIGNED
    } req_state_t;

    logic stall_req;
    logic stall_oc;

    // OC stage
    logic       oc_valid;
    ldu_issue_t oc_issue;
    logic       oc_a_saved;
    word_t      oc_a_saved_data;
    word_t      oc_a;
    logic       oc_launch;
    logic       next_req_valid;

    // REQ stage
    req_state_t req_state, next_state;
    ldu_op_t    req_op;
    logic [11:0] req_imm12;
    word_t      req_base;
    cq_index_t  req_cq_index;
    va32_t      req_va;
    va32_t      req_out_va;
    logic       req_is_mq;
    logic       req_misaligned;
    byte_mask_t base_mask;
    logic [7:0] wide_mask;

    // ----------------------------------------
    // OC stage

    assign stall_oc = oc_valid & stall_req;

    // operand present from any source
    assign oc_launch = ~stall_oc
        & (oc_issue.A_is_zero | oc_a_saved | oc_issue.A_forward | A_reg_read_ack);

    assign issue_ready    = ~oc_valid | oc_launch;
    assign next_req_valid = oc_valid & oc_launch;

    always_comb begin
        if (oc_issue.A_is_zero) begin
            oc_a = '0;
        end else if (oc_a_saved) begin
            oc_a = oc_a_saved_data;
        end else if (oc_issue.A_forward) begin
            oc_a = forward_data_by_bank[oc_issue.A_bank];
        end else begin
            oc_a = reg_read_data_by_bank_by_port[oc_issue.A_bank][A_reg_read_port];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            oc_valid   <= 1'b0;
            oc_a_saved <= 1'b0;
        end else if (issue_ready) begin
            oc_valid   <= issue_valid;
            oc_a_saved <= 1'b0;
        end else begin
            // forward data lasts one cycle, keep it
            oc_a_saved <= oc_a_saved | oc_issue.A_forward | A_reg_read_ack;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            oc_issue <= issue;
        end
        oc_a_saved_data <= oc_a;
    end

    // ----------------------------------------
    // REQ stage

    always_ff @(posedge CLK) begin
        if (~stall_req) begin
            req_op       <= oc_issue.op;
            req_imm12    <= oc_issue.imm12;
            req_base     <= oc_a;
            req_cq_index <= oc_issue.cq_index;
        end
    end

    assign req_va = req_base + {{20{req_imm12[11]}}, req_imm12};

    // mask shifted by offset, upper half spills into the next word
    always_comb begin
        if (req_op[1]) begin
            base_mask = 4'b1111;
        end else if (req_op[0]) begin
            base_mask = 4'b0011;
        end else begin
            base_mask = 4'b0001;
        end
        wide_mask = {4'b0000, base_mask} << req_va[1:0];
    end

    assign req_misaligned = |wide_mask[7:4];

    // outputs and stall from the current state
    always_comb begin
        stall_req = 1'b0;
        REQ_valid = 1'b0;
        req_is_mq = 1'b0;
        case (req_state)
            REQ_ACTIVE: begin
                REQ_valid = 1'b1;
                stall_req = ~REQ_ack | req_misaligned;
            end
            REQ_MISALIGNED: begin
                REQ_valid = 1'b1;
                req_is_mq = 1'b1;
                stall_req = ~REQ_ack;
            end
            default: begin
                stall_req = 1'b0;
            end
        endcase
    end

    always_comb begin
        next_state = req_state;
        case (req_state)
            REQ_IDLE: begin
                next_state = next_req_valid ? REQ_ACTIVE : REQ_IDLE;
            end
            REQ_ACTIVE: begin
                if (REQ_ack && req_misaligned) begin
                    next_state = REQ_MISALIGNED;
                end else if (REQ_ack) begin
                    next_state = next_req_valid ? REQ_ACTIVE : REQ_IDLE;
                end
            end
            REQ_MISALIGNED: begin
                if (REQ_ack) begin
                    next_state = next_req_valid ? REQ_ACTIVE : REQ_IDLE;
                end
            end
            default: begin
                next_state = REQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            req_state <= REQ_IDLE;
        end else begin
            req_state <= next_state;
        end
    end

    // second request goes to the next word
    assign req_out_va = req_is_mq ? req_va + 32'd4 : req_va;

    assign REQ.is_mq      = req_is_mq;
    assign REQ.misaligned = req_misaligned;
    assign REQ.VPN        = req_out_va[31 -: VPN_WIDTH];
    assign REQ.PO_word    = req_out_va[PO_WIDTH-1:2];
    assign REQ.byte_mask  = req_is_mq ? wide_mask[7:4] : wide_mask[3:0];
    assign REQ.cq_index   = req_cq_index;

endmodule

//--- verilog/ldu_top.sv
`timescale 1ns/1ps

module ldu_top
    import core_types_pkg::*;
(
    input  logic          CLK,
    input  logic          nRST,

    // dispatch
    input  logic          dispatch_valid,
    input  ldu_dispatch_t dispatch,
    output logic          dispatch_ready,

    // writeback
    input  prf_wb_t       wb,

    // other register file clients
    input  prf_read_req_t [1:0] ext_read_req,
    output word_t         [1:0] ext_read_data,

    // request toward TLB and cache
    output logic          REQ_valid,
    output ldu_req_t      REQ,
    input  logic          REQ_ack
);

    logic          issue_valid;
    ldu_issue_t    issue;
    logic          issue_ready;

    prf_read_req_t A_reg_read_req;
    logic          A_reg_read_ack;
    logic          A_reg_read_port;

    word_t [PRF_BANK_COUNT-1:0][1:0] reg_read_data_by_bank_by_port;
    word_t [PRF_BANK_COUNT-1:0]      forward_data_by_bank;

    ldu_issue_queue u_iq (
        .CLK            (CLK),
        .nRST           (nRST),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .wb             (wb),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_ready    (issue_ready),
        .A_reg_read_req (A_reg_read_req),
        .A_reg_read_ack (A_reg_read_ack)
    );

    prf_banked u_prf (
        .CLK                           (CLK),
        .nRST                          (nRST),
        .wb                            (wb),
        .ext_read_req                  (ext_read_req),
        .ext_read_data                 (ext_read_data),
        .A_reg_read_req                (A_reg_read_req),
        .A_reg_read_ack                (A_reg_read_ack),
        .A_reg_read_port               (A_reg_read_port),
        .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
        .forward_data_by_bank          (forward_data_by_bank)
    );

    ldu_addr_pipeline u_pipe (
        .CLK                           (CLK),
        .nRST                          (nRST),
        .issue_valid                   (issue_valid),
        .issue                         (issue),
        .issue_ready                   (issue_ready),
        .A_reg_read_ack                (A_reg_read_ack),
        .A_reg_read_port               (A_reg_read_port),
        .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
        .forward_data_by_bank          (forward_data_by_bank),
        .REQ_valid                     (REQ_valid),
        .REQ                           (REQ),
        .REQ_ack                       (REQ_ack)
    );

endmodule

//--- verification/ldu_properties.sv
`timescale 1ns/1ps

module ldu_properties
    import core_types_pkg::*;
(
    input logic     CLK,
    input logic     nRST,
    input logic     issue_valid,
    input logic     issue_ready,
    input logic     REQ_valid,
    input ldu_req_t REQ,
    input logic     REQ_ack
);

    int failure_count = 0;

    // request waiting for ack keeps every field
    req_hold_stable: assert property (
        @(posedge CLK) disable iff (~nRST)
        REQ_valid && !REQ_ack |=> REQ_valid && $stable(REQ)
    ) else begin
        $error("REQ changed while waiting for REQ_ack");
        failure_count++;
    end

    // offered load stays offered until taken
    issue_hold_valid: assert property (
        @(posedge CLK) disable iff (~nRST)
        issue_valid && !issue_ready |=> issue_valid
    ) else begin
        $error("issue_valid dropped before issue_ready");
        failure_count++;
    end

endmodule

bind ldu_addr_pipeline ldu_properties u_props (
    .CLK         (CLK),
    .nRST        (nRST),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .REQ_valid   (REQ_valid),
    .REQ         (REQ),
    .REQ_ack     (REQ_ack)
);

//--- verification/ldu_tb.sv
`timescale 1ns/1ps

module ldu_tb
    import system_types_pkg::*;
    import core_types_pkg::*;
();

    // all tests together take a few hundred cycles with random ack
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int RANDOM_LOADS   = 40;

    logic                CLK;
    logic                nRST;
    logic                dispatch_valid;
    ldu_dispatch_t       dispatch;
    logic                dispatch_ready;
    prf_wb_t             wb;
    prf_read_req_t [1:0] ext_read_req;
    word_t         [1:0] ext_read_data;
    logic                REQ_valid;
    ldu_req_t            REQ;
    logic                REQ_ack;

    word_t    reg_model [PRF_COUNT];
    ldu_req_t expected_reqs [LDU_CQ_ENTRIES][$];
    ldu_req_t expected_req;
    int       pending;
    int       error_count;
    int       check_count;
    int       cycle_count;
    logic     random_ack;
    integer   seed;
    string    test_name;

    ldu_top uut (
        .CLK            (CLK),
        .nRST           (nRST),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .wb             (wb),
        .ext_read_req   (ext_read_req),
        .ext_read_data  (ext_read_data),
        .REQ_valid      (REQ_valid),
        .REQ            (REQ),
        .REQ_ack        (REQ_ack)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // cache side ack is high unless randomized
    initial begin
        logic [31:0] ack_bits;
        logic        next_ack;
        REQ_ack = 1'b0;
        forever begin
            @(negedge CLK);
            ack_bits = $random(seed);
            next_ack = random_ack ? ack_bits[0] : 1'b1;
            @(posedge CLK);
            #1;
            REQ_ack = next_ack;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("run stopped after %0d cycles before the tests finished", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ----------------------------------------
    // checking and scoreboard

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("** Error [%s]: expected %h, actual %h", name, expected, actual);
        end
    endtask

    always @(negedge CLK) begin
        if (nRST && REQ_valid && REQ_ack) begin
            if (expected_reqs[REQ.cq_index].size() == 0) begin
                error_count++;
                $display("unexpected request for load %0d in test %s", REQ.cq_index, test_name);
            end else begin
                expected_req = expected_reqs[REQ.cq_index].pop_front();
                pending--;
                check_equal(test_name, expected_req, REQ);
            end
        end
    end

    function automatic byte_mask_t first_mask(input ldu_op_t op, input logic [1:0] offset);
        if (op == LW) begin
            return 4'b1111 << offset;
        end else if (op == LH || op == LHU) begin
            return (offset == 2'd3) ? 4'b1000 : 4'b0011 << offset;
        end
        return 4'b0001 << offset;
    endfunction

    // bytes that spill into the next word
    function automatic byte_mask_t spill_mask(input ldu_op_t op, input logic [1:0] offset);
        if (op != LW) begin
            return 4'b0001;
        end
        case (offset)
            2'd1:    return 4'b0001;
            2'd2:    return 4'b0011;
            default: return 4'b0111;
        endcase
    endfunction

    task automatic expect_load(input ldu_op_t op, input logic [11:0] imm, input word_t base,
                               input cq_index_t cq);
        va32_t    va;
        logic     split;
        ldu_req_t r;
        va    = base + {{20{imm[11]}}, imm};
        split = (op == LW && va[1:0] != 2'd0) || ((op == LH || op == LHU) && va[1:0] == 2'd3);
        r.is_mq      = 1'b0;
        r.misaligned = split;
        r.VPN        = va[31:12];
        r.PO_word    = va[11:2];
        r.byte_mask  = first_mask(op, va[1:0]);
        r.cq_index   = cq;
        expected_reqs[cq].push_back(r);
        pending++;
        if (split) begin
            va          = va + 32'd4;
            r.is_mq     = 1'b1;
            r.VPN       = va[31:12];
            r.PO_word   = va[11:2];
            r.byte_mask = spill_mask(op, va[1:0]);
            expected_reqs[cq].push_back(r);
            pending++;
        end
    endtask

    // ----------------------------------------
    // stimulus tasks start and end just after a rising edge

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic write_reg(input preg_t p, input word_t data);
        wb.valid = 1'b1;
        wb.preg  = p;
        wb.data  = data;
        if (p != '0) begin
            reg_model[p] = data;
        end
        idle_cycles(1);
        wb.valid = 1'b0;
    endtask

    task automatic dispatch_load(input ldu_op_t op, input logic [11:0] imm, input preg_t src,
                                 input logic src_ready, input cq_index_t cq);
        dispatch_valid     = 1'b1;
        dispatch.op        = op;
        dispatch.imm12     = imm;
        dispatch.src_preg  = src;
        dispatch.src_ready = src_ready;
        dispatch.cq_index  = cq;
        @(negedge CLK);
        while (!dispatch_ready) begin
            @(negedge CLK);
        end
        idle_cycles(1);
        dispatch_valid = 1'b0;
    endtask

    task automatic ready_load(input ldu_op_t op, input logic [11:0] imm, input preg_t src,
                              input cq_index_t cq);
        expect_load(op, imm, reg_model[src], cq);
        dispatch_load(op, imm, src, 1'b1, cq);
    endtask

    task automatic wait_drained();
        while (pending != 0) begin
            idle_cycles(1);
        end
    endtask

    // ----------------------------------------
    // directed tests

    task automatic test_aligned();
        test_name = "aligned";
        write_reg(5'd1, 32'h1234_5000);
        write_reg(5'd2, 32'h8000_0ff0);
        write_reg(5'd3, 32'h0000_1002);
        ready_load(LB, 12'h123, 5'd0, 3'd0);
        ready_load(LH, 12'h006, 5'd1, 3'd1);
        ready_load(LW, 12'h010, 5'd2, 3'd2);
        ready_load(LBU, 12'hffe, 5'd3, 3'd3);
        ready_load(LHU, 12'h7fc, 5'd0, 3'd4);
        ready_load(LW, 12'h800, 5'd0, 3'd5);
        wait_drained();
    endtask

    task automatic test_misaligned();
        test_name = "misaligned";
        ready_load(LW, 12'h001, 5'd1, 3'd0);
        ready_load(LW, 12'h002, 5'd1, 3'd1);
        ready_load(LW, 12'h003, 5'd1, 3'd2);
        ready_load(LH, 12'h003, 5'd1, 3'd3);
        // crosses into the next page
        ready_load(LH, 12'h00f, 5'd2, 3'd4);
        wait_drained();
    endtask

    task automatic test_wakeup();
        test_name = "wakeup";
        dispatch_load(LW, 12'h008, 5'd7, 1'b0, 3'd6);
        dispatch_load(LH, 12'h00b, 5'd7, 1'b0, 3'd7);
        idle_cycles(6);
        @(negedge CLK);
        check_equal(test_name, 0, uut.issue_valid);
        idle_cycles(1);
        expect_load(LW, 12'h008, 32'h0040_2000, 3'd6);
        expect_load(LH, 12'h00b, 32'h0040_2000, 3'd7);
        write_reg(5'd7, 32'h0040_2000);
        wait_drained();
    endtask

    task automatic test_bank_conflict();
        test_name = "bank_conflict";
        write_reg(5'd5, 32'h0abc_d100);
        write_reg(5'd9, 32'h1111_2222);
        write_reg(5'd13, 32'h3333_4444);
        ext_read_req[0].valid = 1'b1;
        ext_read_req[0].preg  = 5'd9;
        ext_read_req[1].valid = 1'b1;
        ext_read_req[1].preg  = 5'd13;
        ready_load(LW, 12'h004, 5'd5, 3'd0);
        repeat (6) begin
            @(negedge CLK);
            check_equal(test_name, reg_model[9], ext_read_data[0]);
            check_equal(test_name, reg_model[13], ext_read_data[1]);
            idle_cycles(1);
        end
        // still waiting for a read port
        check_equal(test_name, 1, expected_reqs[0].size());
        ext_read_req = '0;
        wait_drained();
    endtask

    task automatic test_random_pressure();
        ldu_op_t     ops [5];
        logic [31:0] pick;
        int          idx;
        ops = '{LB, LH, LW, LBU, LHU};
        test_name = "random_pressure";
        for (int p = 1; p < 16; p++) begin
            write_reg(preg_t'(p), word_t'($random(seed)));
        end
        random_ack = 1'b1;
        for (int n = 0; n < RANDOM_LOADS; n++) begin
            pick = $random(seed);
            idx  = int'(pick[30:28] % 3'd5);
            ready_load(ops[idx], pick[19:8], preg_t'(pick[7:4]), cq_index_t'(n));
        end
        wait_drained();
        random_ack = 1'b0;
    endtask

    // ----------------------------------------
    // main sequence

    initial begin
        seed           = 32'h293a5eca;
        nRST           = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        wb             = '0;
        ext_read_req   = '0;
        random_ack     = 1'b0;
        pending        = 0;
        error_count    = 0;
        check_count    = 0;
        test_name      = "reset";
        for (int i = 0; i < PRF_COUNT; i++) begin
            reg_model[i] = '0;
        end
        repeat (16) @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(negedge CLK);
        check_equal(test_name, 1, dispatch_ready);
        check_equal(test_name, 0, uut.issue_valid);
        check_equal(test_name, 0, uut.A_reg_read_req.valid);
        check_equal(test_name, 0, REQ_valid);
        idle_cycles(1);

        test_aligned();
        test_misaligned();
        test_wakeup();
        test_bank_conflict();
        test_random_pressure();

        $display("checks run: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, uut.u_pipe.u_props.failure_count);
        if (error_count == 0 && uut.u_pipe.u_props.failure_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
verilog/system_types_pkg.sv
verilog/core_types_pkg.sv
verilog/ldu_issue_queue.sv
verilog/prf_banked.sv
verilog/ldu_addr_pipeline.sv
verilog/ldu_top.sv
verification/ldu_properties.sv
verification/ldu_tb.sv

//--- Makefile
TOP := ldu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
